// File: verilog/dac_pkg.sv
package dac_pkg;

	////////////////////
	// frame format
	////////////////////

	localparam int W_DATA = 16;		// width of one dac sample
	localparam int N_CHAN = 8;		// number of dac channels
	localparam int W_CHS = 3;		// width of a channel number
	localparam int W_CMD = 4;		// command nibble
	localparam int W_ADDR = 4;		// address nibble, msb always zero here
	localparam int W_FRAME = W_CMD + W_ADDR + W_DATA;	// 24 bit serial frame

	// write input register and update the output in one go
	localparam logic [W_CMD-1:0] DAC_CMD_WRITE_UPDATE = 4'b0011;

	////////////////////
	// instruction word
	////////////////////

	// one queued dac write, channel on top, sample below
	typedef struct packed {
		logic [W_CHS-1:0] chan;		// target channel 0..7
		logic [W_DATA-1:0] data;	// sample to write
	} dac_instr_t;

	// 19 bits in all
	localparam int W_INSTR = W_CHS + W_DATA;

endpackage

// File: verilog/chan_pair_encoder.sv
`timescale 1ns/100ps

module chan_pair_encoder (
	input logic clk_in,
	input logic arst_n,
	input logic [dac_pkg::W_DATA*dac_pkg::N_CHAN-1:0] data_packed,	// ch0 in low 16 bits
	input logic [dac_pkg::N_CHAN-1:0] data_valid,	// one-hot per half
	output logic push,					// write strobe to the queue
	output dac_pkg::dac_instr_t instr	// instruction for the queue
);

	localparam int N_HALF = dac_pkg::N_CHAN / 2;	// channels per half
	localparam int W_HALF = dac_pkg::W_DATA * N_HALF;	// bits per half of the bus
	localparam int W_IDX = dac_pkg::W_CHS - 1;		// index inside a half

	// one-hot valid word to binary index, 0 if no bit set
	function automatic logic [W_IDX-1:0] idx_from_oh(input logic [N_HALF-1:0] oh);
		logic [W_IDX-1:0] idx;
		idx = '0;
		for (int i = 0; i < N_HALF; i++) begin
			if (oh[i])
				idx = i[W_IDX-1:0];
		end
		return idx;
	endfunction

	////////////////////
	// split halves
	////////////////////

	logic [W_HALF-1:0] lo_bus, up_bus;		// sample words per half
	logic [N_HALF-1:0] lo_vld, up_vld;		// valid bits per half
	logic [W_IDX-1:0] lo_idx, up_idx;		// selected slot per half
	logic lo_ok, up_ok;						// half carries exactly one sample
	dac_pkg::dac_instr_t lo_instr_d, up_instr_d;

	assign lo_bus = data_packed[W_HALF-1:0];
	assign up_bus = data_packed[2*W_HALF-1:W_HALF];
	assign lo_vld = data_valid[N_HALF-1:0];
	assign up_vld = data_valid[dac_pkg::N_CHAN-1:N_HALF];

	assign lo_ok = $onehot(lo_vld);		// zero or several bits means drop the half
	assign up_ok = $onehot(up_vld);
	assign lo_idx = idx_from_oh(lo_vld);
	assign up_idx = idx_from_oh(up_vld);

	always_comb begin
		lo_instr_d.chan = {1'b0, lo_idx};	// channels 0..3
		lo_instr_d.data = lo_bus[lo_idx*dac_pkg::W_DATA +: dac_pkg::W_DATA];
		up_instr_d.chan = {1'b1, up_idx};	// msb set gives index + 4
		up_instr_d.data = up_bus[up_idx*dac_pkg::W_DATA +: dac_pkg::W_DATA];
	end

	////////////////////
	// ordering stages
	////////////////////

	logic lo_vld_q;			// lower instr ready, input + 1
	logic up_vld_q;			// upper instr waiting, input + 1
	logic up_vld_qq;		// upper instr ready, input + 2
	dac_pkg::dac_instr_t lo_instr_q, up_instr_q, up_instr_qq;

	// valid strobes for both halves
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			lo_vld_q <= 1'b0;
			up_vld_q <= 1'b0;
			up_vld_qq <= 1'b0;
		end else begin
			lo_vld_q <= lo_ok;
			up_vld_q <= up_ok;
			up_vld_qq <= up_vld_q;		// extra slot so lower goes first
		end
	end

	always_ff @(posedge clk_in) begin
		lo_instr_q <= lo_instr_d;
		up_instr_q <= up_instr_d;
		up_instr_qq <= up_instr_q;
	end

	// pairs come at least two cycles apart, so both never hit the same cycle
	assign push = lo_vld_q | up_vld_qq;
	assign instr = lo_vld_q ? lo_instr_q : up_instr_qq;	// lower wins the slot

endmodule

// File: verilog/instr_queue.sv
`timescale 1ns/100ps

module instr_queue #(
	parameter int FIFO_DEPTH = 16,	// entries, power of two
	parameter int N_CREDIT = 2		// credits held at reset
) (
	input logic clk_in,
	input logic arst_n,
	input logic push,						// write strobe from the encoder
	input dac_pkg::dac_instr_t push_instr,	// instruction to store
	input logic credit_return,				// writer freed a holding slot
	output logic instr_valid,				// one-cycle send strobe
	output dac_pkg::dac_instr_t instr,		// instruction being sent
	output logic queue_overflow				// sticky, a push was dropped
);

	localparam int W_PTR = $clog2(FIFO_DEPTH);		// pointer width
	localparam int W_CNT = W_PTR + 1;				// occupancy 0..FIFO_DEPTH
	localparam int W_CRED = $clog2(N_CREDIT + 1);	// credit count 0..N_CREDIT

	////////////////////
	// storage
	////////////////////

	dac_pkg::dac_instr_t mem [FIFO_DEPTH];	// circular buffer
	logic [W_PTR-1:0] wr_ptr;				// next slot to write
	logic [W_PTR-1:0] rd_ptr;				// oldest entry
	logic [W_CNT-1:0] count;				// entries held
	logic [W_CRED-1:0] credits;				// slots free in the writer

	logic full, empty;
	logic do_push;		// push that fits
	logic pop;			// entry leaves this cycle

	assign full = (count == W_CNT'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign do_push = push & ~full;
	assign pop = ~empty & (credits != '0);	// only send with credit in hand

	////////////////////
	// pointers, count
	////////////////////

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps on its own, depth is 2^n
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + W_CNT'(do_push) - W_CNT'(pop);
		end
	end

	always_ff @(posedge clk_in) begin
		if (do_push)
			mem[wr_ptr] <= push_instr;
	end

	////////////////////
	// credits
	////////////////////

	// return and send in one cycle cancel out
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n)
			credits <= W_CRED'(N_CREDIT);
		else
			credits <= credits + W_CRED'(credit_return) - W_CRED'(pop);
	end

	////////////////////
	// send, overflow
	////////////////////

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			instr_valid <= 1'b0;
			queue_overflow <= 1'b0;
		end else begin
			instr_valid <= pop;		// registered strobe, one cycle per pop
			if (push && full)
				queue_overflow <= 1'b1;	// held until reset
		end
	end

	// payload register for the outgoing entry
	always_ff @(posedge clk_in) begin
		if (pop)
			instr <= mem[rd_ptr];
	end

endmodule

// File: verilog/dac_serial_writer.sv
`timescale 1ns/100ps

module dac_serial_writer #(
	parameter int N_CREDIT = 2		// holding buffer depth
) (
	input logic clk_in,
	input logic arst_n,
	input logic instr_valid,			// entry from the queue
	input dac_pkg::dac_instr_t instr,	// its payload
	output logic credit_return,			// pulse per entry moved to the shifter
	output logic sync_n,				// frame strobe, low for the whole frame
	output logic sclk,					// serial clock, clk_in / 2
	output logic sdi					// serial data, msb first
);

	localparam int W_HP = (N_CREDIT > 1) ? $clog2(N_CREDIT) : 1;	// holding ptr width
	localparam int W_HC = $clog2(N_CREDIT + 1);		// holding count width
	localparam int N_PHASE = 2 * dac_pkg::W_FRAME;	// 48 clk_in cycles per frame
	localparam int N_GAP = 2;						// sync_n high between frames
	localparam int W_CNT = $clog2(N_PHASE);

	////////////////////
	// holding buffer
	////////////////////

	dac_pkg::dac_instr_t hold_mem [N_CREDIT];
	logic [W_HP-1:0] hold_wr;		// next free slot
	logic [W_HP-1:0] hold_rd;		// oldest entry
	logic [W_HC-1:0] hold_cnt;		// entries waiting
	logic load;						// oldest entry goes to the shifter

	// credits keep the buffer from ever overrunning
	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			hold_wr <= '0;
			hold_rd <= '0;
			hold_cnt <= '0;
		end else begin
			if (instr_valid)
				hold_wr <= (hold_wr == W_HP'(N_CREDIT - 1)) ? '0 : hold_wr + 1'b1;
			if (load)
				hold_rd <= (hold_rd == W_HP'(N_CREDIT - 1)) ? '0 : hold_rd + 1'b1;
			hold_cnt <= hold_cnt + W_HC'(instr_valid) - W_HC'(load);
		end
	end

	always_ff @(posedge clk_in) begin
		if (instr_valid)
			hold_mem[hold_wr] <= instr;
	end

	////////////////////
	// frame shifter
	////////////////////

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SHIFT,
		ST_GAP
	} state_t;

	state_t state;
	logic [W_CNT-1:0] cnt;		// half-bit phase in shift, cycles in gap
	logic [dac_pkg::W_FRAME-1:0] frame;		// frame built from the oldest entry
	logic [dac_pkg::W_FRAME-1:0] shift_reg;	// bits still to go, msb next
	logic shifter_free;

	// cmd, then 0 + channel as the address, then data
	assign frame = {dac_pkg::DAC_CMD_WRITE_UPDATE, 1'b0, hold_mem[hold_rd].chan,
		hold_mem[hold_rd].data};

	// last gap cycle may already start the next frame
	assign shifter_free = (state == ST_IDLE) ||
		(state == ST_GAP && cnt == W_CNT'(N_GAP - 1));
	assign load = shifter_free & (hold_cnt != '0);

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			cnt <= '0;
			sync_n <= 1'b1;
			sclk <= 1'b0;
			sdi <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			credit_return <= load;		// one credit back per load
			if (load) begin
				state <= ST_SHIFT;
				cnt <= '0;
				sync_n <= 1'b0;
				sclk <= 1'b0;
				sdi <= frame[dac_pkg::W_FRAME-1];	// first bit set up before first rise
			end else begin
				case (state)
					ST_SHIFT: begin
						if (cnt == W_CNT'(N_PHASE - 1)) begin
							state <= ST_GAP;		// frame done
							cnt <= '0;
							sync_n <= 1'b1;
							sclk <= 1'b0;
							sdi <= 1'b0;
						end else begin
							cnt <= cnt + 1'b1;
							sclk <= ~sclk;
							if (sclk)
								sdi <= shift_reg[dac_pkg::W_FRAME-1];	// change on fall
						end
					end
					ST_GAP: begin
						if (cnt == W_CNT'(N_GAP - 1))
							state <= ST_IDLE;
						else
							cnt <= cnt + 1'b1;
					end
					default: begin
						cnt <= '0;		// idle, wait for an entry
					end
				endcase
			end
		end
	end

	// payload shift, msb leaves first
	always_ff @(posedge clk_in) begin
		if (load)
			shift_reg <= {frame[dac_pkg::W_FRAME-2:0], 1'b0};	// msb already on sdi
		else if (state == ST_SHIFT && sclk)
			shift_reg <= {shift_reg[dac_pkg::W_FRAME-2:0], 1'b0};
	end

endmodule

// File: verilog/dac_write_sched.sv
`timescale 1ns/100ps

module dac_write_sched #(
	parameter int FIFO_DEPTH = 16,	// queue entries, power of two
	parameter int N_CREDIT = 2		// credits, equals writer holding depth
) (
	input logic clk_in,
	input logic arst_n,
	input logic [dac_pkg::W_DATA*dac_pkg::N_CHAN-1:0] data_packed,	// 8 samples
	input logic [dac_pkg::N_CHAN-1:0] data_valid,	// one-hot per half
	output logic sync_n,			// dac frame sync
	output logic sclk,				// dac serial clock
	output logic sdi,				// dac serial data
	output logic queue_overflow		// sticky drop flag
);

	////////////////////
	// internal links
	////////////////////

	logic push;							// encoder to queue strobe
	dac_pkg::dac_instr_t push_instr;
	logic instr_valid;					// queue to writer strobe
	dac_pkg::dac_instr_t send_instr;
	logic credit_return;				// writer back to queue

	// input side
	chan_pair_encoder u_encoder (
		.clk_in      (clk_in),
		.arst_n      (arst_n),
		.data_packed (data_packed),
		.data_valid  (data_valid),
		.push        (push),
		.instr       (push_instr)
	);

	// queue with credit gate
	instr_queue #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.N_CREDIT   (N_CREDIT)
	) u_queue (
		.clk_in         (clk_in),
		.arst_n         (arst_n),
		.push           (push),
		.push_instr     (push_instr),
		.credit_return  (credit_return),
		.instr_valid    (instr_valid),
		.instr          (send_instr),
		.queue_overflow (queue_overflow)
	);

	// serial frames out to the dac
	dac_serial_writer #(
		.N_CREDIT (N_CREDIT)		// same value as the queue's start credit
	) u_writer (
		.clk_in        (clk_in),
		.arst_n        (arst_n),
		.instr_valid   (instr_valid),
		.instr         (send_instr),
		.credit_return (credit_return),
		.sync_n        (sync_n),
		.sclk          (sclk),
		.sdi           (sdi)
	);

endmodule

// File: tests/tb_dac_write_sched.sv
`timescale 1ns/100ps

module tb_dac_write_sched;

	localparam int FIFO_DEPTH = 16;		// dut default
	localparam int MAX_CYCLES = 8000;	// ~120 frames of 50 cycles plus margin
	localparam int QUIET_CYCLES = 16;	// sync_n high this long, link drained
	localparam int DRAIN_LIMIT = 3000;	// per-task wait, longest burst needs ~1100
	localparam int T_DRIVE = 1;			// input skew after the rising edge
	localparam int W_BUS = dac_pkg::W_DATA * dac_pkg::N_CHAN;
	localparam logic [3:0] CMD_WR_UPDATE = 4'b0011;	// write input reg and update

	logic clk_in, arst_n;
	logic [W_BUS-1:0] data_packed;
	logic [dac_pkg::N_CHAN-1:0] data_valid;
	logic sync_n, sclk, sdi, queue_overflow;

	logic [dac_pkg::W_FRAME-1:0] exp_q[$];	// frames in rule order
	logic [dac_pkg::W_FRAME-1:0] rx_q[$];	// frames seen on the pins
	int n_broken;		// frames cut short by sync_n
	int value_errs;		// wrong values
	int other_errs;		// missing frames, broken frames, stalls
	int cycle_cnt;

	dac_write_sched u_dut (
		.clk_in         (clk_in),
		.arst_n         (arst_n),
		.data_packed    (data_packed),
		.data_valid     (data_valid),
		.sync_n         (sync_n),
		.sclk           (sclk),
		.sdi            (sdi),
		.queue_overflow (queue_overflow)
	);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;	// 40 ns period
	end

	////////////////////
	// frame capture
	////////////////////

	// one bit per sclk rise while sync_n is low
	initial begin : capture
		logic [dac_pkg::W_FRAME-1:0] shreg;
		int n_bits;
		shreg = '0;
		n_bits = 0;
		n_broken = 0;
		forever begin
			@(posedge sclk or posedge sync_n);
			if (sync_n) begin
				if (n_bits != 0 && arst_n)
					n_broken++;		// sync_n rose mid frame
				n_bits = 0;
			end else begin
				shreg = {shreg[dac_pkg::W_FRAME-2:0], sdi};	// msb first
				n_bits++;
				if (n_bits == dac_pkg::W_FRAME) begin
					rx_q.push_back(shreg);
					n_bits = 0;
				end
			end
		end
	end

	// cycle counter, ends a hung run
	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge clk_in);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	////////////////////
	// helpers
	////////////////////

	task automatic apply_reset();
		@(posedge clk_in);
		#T_DRIVE arst_n = 1'b0;
		repeat (3) @(posedge clk_in);
		#T_DRIVE arst_n = 1'b1;
	endtask

	// new word on every slot so a wrong select shows up
	task automatic randomize_bus();
		for (int ch = 0; ch < dac_pkg::N_CHAN; ch++)
			data_packed[ch*dac_pkg::W_DATA +: dac_pkg::W_DATA] = 16'($urandom);
	endtask

	// one sample cycle, then a cycle with valid low
	task automatic drive_cycle(input logic [dac_pkg::N_CHAN-1:0] vld);
		@(posedge clk_in);
		#T_DRIVE;
		randomize_bus();
		data_valid = vld;
		@(posedge clk_in);
		#T_DRIVE data_valid = '0;		// bus data kept for expect_frame
	endtask

	// cmd nibble, 4-bit address, sample from the bus as driven
	task automatic expect_frame(input int ch);
		dac_pkg::dac_instr_t ins;
		ins.chan = ch[dac_pkg::W_CHS-1:0];
		ins.data = data_packed[ch*dac_pkg::W_DATA +: dac_pkg::W_DATA];
		exp_q.push_back({CMD_WR_UPDATE, 4'(ins.chan), ins.data});
	endtask

	// done when sync_n has stayed high for a while
	task automatic wait_drain();
		int quiet;
		int waited;
		quiet = 0;
		waited = 0;
		while (quiet < QUIET_CYCLES && waited < DRAIN_LIMIT) begin
			@(posedge clk_in);
			#T_DRIVE waited++;
			quiet = sync_n ? quiet + 1 : 0;
		end
		if (quiet < QUIET_CYCLES) begin
			$display("serial link still busy after %0d cycles", DRAIN_LIMIT);
			other_errs++;
		end
	endtask

	task automatic verify_level(input string sig, input logic got, input logic want);
		if (got !== want) begin
			$display("FAIL %s: expected 0x%h, got 0x%h", sig, want, got);
			value_errs++;
		end
	endtask

	task automatic check_broken(input string name);
		if (n_broken != 0) begin
			$display("%s: %0d frames ended early", name, n_broken);
			other_errs++;
		end
		n_broken = 0;
		rx_q.delete();
		exp_q.delete();
	endtask

	// exact match, frame by frame
	task automatic compare_frames(input string name);
		int n;
		n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
		if (rx_q.size() != exp_q.size()) begin
			$display("%s: expected %0d frames, received %0d", name, exp_q.size(),
				rx_q.size());
			other_errs++;
		end
		for (int i = 0; i < n; i++) begin
			if (rx_q[i] !== exp_q[i]) begin
				$display("FAIL %s frame %0d sdi: expected 0x%06h, got 0x%06h", name, i,
					exp_q[i], rx_q[i]);
				value_errs++;
			end
		end
		check_broken(name);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic check_after_reset();
		verify_level("sync_n", sync_n, 1'b1);
		verify_level("sclk", sclk, 1'b0);
		verify_level("queue_overflow", queue_overflow, 1'b0);
		drive_cycle(8'b0000_0100);		// lower half, channel 2
		expect_frame(2);
		wait_drain();
		compare_frames("reset");
	endtask

	task automatic upper_half_frame();
		drive_cycle(8'b0010_0000);		// upper index 1 is channel 5
		expect_frame(5);
		wait_drain();
		compare_frames("upper");
	endtask

	task automatic simultaneous_pairs();
		for (int p = 0; p < 4; p++) begin
			drive_cycle(8'(1 << p) | 8'(1 << (p + 4)));
			expect_frame(p);			// lower goes out first
			expect_frame(p + 4);
			repeat (4) @(posedge clk_in);
		end
		wait_drain();
		compare_frames("pairs");
	endtask

	task automatic invalid_halves();
		drive_cycle(8'b0100_0000);		// lower empty, upper ch 6 kept
		expect_frame(6);
		drive_cycle(8'b0000_0011);		// two lower bits, nothing
		drive_cycle(8'b1001_1000);		// lower ch 3 kept, upper dropped
		expect_frame(3);
		drive_cycle(8'b1100_0101);		// both halves bad
		wait_drain();
		compare_frames("invalid");
	endtask

	task automatic overflow_burst();
		int j;
		logic lost;
		j = 0;
		lost = 1'b0;
		for (int i = 0; i < 40; i++) begin
			drive_cycle(8'(1 << (i % 4)) | 8'(1 << (4 + (i + 1) % 4)));
			expect_frame(i % 4);
			expect_frame(4 + (i + 1) % 4);
		end
		wait_drain();
		verify_level("queue_overflow", queue_overflow, 1'b1);
		// received frames must appear in the expected list, in order
		for (int k = 0; k < rx_q.size() && !lost; k++) begin
			while (j < exp_q.size() && exp_q[j] !== rx_q[k])
				j++;
			if (j == exp_q.size()) begin
				$display("overflow: frame %0d (0x%06h) out of order or unknown", k, rx_q[k]);
				other_errs++;
				lost = 1'b1;
			end
			j++;
		end
		if (rx_q.size() < FIFO_DEPTH) begin
			$display("overflow: only %0d frames received, at least %0d expected",
				rx_q.size(), FIFO_DEPTH);
			other_errs++;
		end
		check_broken("overflow");
		apply_reset();
		verify_level("queue_overflow", queue_overflow, 1'b0);	// cleared by reset
	endtask

	initial begin : main
		void'($urandom(10684));
		value_errs = 0;
		other_errs = 0;
		arst_n = 1'b0;
		data_packed = '0;
		data_valid = '0;
		apply_reset();
		check_after_reset();
		upper_half_frame();
		simultaneous_pairs();
		invalid_halves();
		overflow_burst();
		$display("errors: value %0d, other %0d", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: dac_write_sched.f
verilog/dac_pkg.sv
verilog/chan_pair_encoder.sv
verilog/instr_queue.sv
verilog/dac_serial_writer.sv
verilog/dac_write_sched.sv
tests/tb_dac_write_sched.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_dac_write_sched
FILELIST  = dac_write_sched.f
OBJ_DIR   = obj_dir
PASS_MSG  = RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status follows the search for the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

.PHONY: build
